// File: src/nes_settings.svh
// ----------------------------------------
// NES DMA settings
// Divider lengths, OAM port address, APB
// address width and sprite transfer size
// ----------------------------------------
`ifndef NES_SETTINGS_SVH
`define NES_SETTINGS_SVH

// Master clocks per NTSC CPU cycle
`define NES_DIV_CPU 12

// PAL stretches one CPU cycle per group
`define NES_PAL_EXTRA 4   // Extra master clocks on the long cycle
`define NES_PAL_GROUP 5   // CPU cycles per PAL group, last one is long

// OAM data port, the write target of sprite DMA
`define NES_OAM_DATA_ADDR 16'h2004

// APB slave address width
`define NES_APB_AW 5

// One full sprite page
`define NES_SPR_BYTES 256

`endif

// File: src/nes_bus_pkg.sv
// ----------------------------------------
// NES CPU bus types
// Address and data of the CPU-side bus and
// the video standard select
// ----------------------------------------
package nes_bus_pkg;

  // 6502 address space is 64K
  typedef logic [15:0] cpu_addr_t;

  // Byte wide data bus
  typedef logic [7:0] cpu_data_t;

  // Video standard, sets the CPU clock pacing
  typedef enum logic {
    VIDEO_NTSC = 1'b0,  // 12 master clocks per CPU cycle
    VIDEO_PAL  = 1'b1   // Every fifth CPU cycle stretched
  } video_std_t;

endpackage

// File: src/dma_regs_pkg.sv
// ----------------------------------------
// DMA register map
// APB offsets and status bit positions of
// the DMA register block
// ----------------------------------------
`include "nes_settings.svh"

package dma_regs_pkg;

  // Register offsets on the APB bus
  typedef enum logic [`NES_APB_AW-1:0] {
    REG_CTRL        = 0,  // Bit0 selects PAL
    REG_SPR_PAGE    = 1,  // Write starts sprite DMA
    REG_DMC_ADDR_LO = 2,
    REG_DMC_ADDR_HI = 3,
    REG_DMC_REQ     = 4,  // Write 1 requests a sample fetch
    REG_DMC_DATA    = 5,  // Read only, last fetched byte
    REG_STATUS      = 6   // Read only
  } reg_offset_t;

  // STATUS bits
  localparam int STATUS_SPR_BUSY = 0;  // Sprite DMA pending or running
  localparam int STATUS_DMC_PEND = 1;  // Sample fetch not yet served

endpackage

// File: src/nes_clock_div.sv
// ----------------------------------------
// NES CPU clock enable generator
// Divides the master clock to CPU cycles
// and tracks the odd/even cycle flag
// ----------------------------------------
`timescale 1ns/10ps
`include "nes_settings.svh"

module nes_clock_div (
  input  logic                    clk,
  input  logic                    reset,
  input  nes_bus_pkg::video_std_t video_std,
  output logic                    cpu_ce,     // One clock per CPU cycle
  output logic                    odd_cycle   // 1 = odd, 0 = even
);

  localparam int CNT_W = $clog2(`NES_DIV_CPU + `NES_PAL_EXTRA);
  localparam int GRP_W = $clog2(`NES_PAL_GROUP);

  logic [CNT_W-1:0]        div_cnt;   // Master clocks into this CPU cycle
  logic [GRP_W-1:0]        grp_cnt;   // Position inside the PAL group
  logic [CNT_W-1:0]        cyc_last;  // Terminal count of this cycle
  logic                    long_cyc;
  logic                    std_chg;
  nes_bus_pkg::video_std_t last_std;

  assign std_chg  = (video_std != last_std);  // Realign on standard switch
  assign long_cyc = (video_std == nes_bus_pkg::VIDEO_PAL) &&
                    (grp_cnt == GRP_W'(`NES_PAL_GROUP - 1));

  // PAL adds a few clocks to the last cycle of each group
  assign cyc_last = long_cyc ? CNT_W'(`NES_DIV_CPU + `NES_PAL_EXTRA - 1)
                             : CNT_W'(`NES_DIV_CPU - 1);

  assign cpu_ce = (div_cnt == cyc_last) && !std_chg;

  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt   <= '0;
      grp_cnt   <= '0;
      last_std  <= nes_bus_pkg::VIDEO_NTSC;
      odd_cycle <= 1'b1;  // First CPU cycle after reset is odd
    end else begin
      last_std <= video_std;
      if (std_chg) begin
        div_cnt <= '0;    // Restart divider and group
        grp_cnt <= '0;
      end else if (cpu_ce) begin
        div_cnt   <= '0;
        odd_cycle <= ~odd_cycle;
        if (video_std == nes_bus_pkg::VIDEO_PAL) begin
          grp_cnt <= long_cyc ? '0 : grp_cnt + 1'b1;
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule

// File: src/dma_reg_block.sv
// ----------------------------------------
// DMA register block
// Zero-wait APB slave with the control,
// sprite page and DMC fetch registers
// ----------------------------------------
`timescale 1ns/10ps
`include "nes_settings.svh"

module dma_reg_block (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [`NES_APB_AW-1:0]  paddr,
  input  nes_bus_pkg::cpu_data_t  pwdata,
  output nes_bus_pkg::cpu_data_t  prdata,
  output logic                    pready,
  output logic                    pslverr,
  input  logic                    spr_busy,
  input  logic                    dmc_ack,
  input  logic                    dmc_data_valid,
  input  nes_bus_pkg::cpu_data_t  dmc_data,
  output nes_bus_pkg::video_std_t video_std,
  output logic                    spr_start,
  output nes_bus_pkg::cpu_data_t  spr_page,
  output logic                    dmc_req,
  output nes_bus_pkg::cpu_addr_t  dmc_addr
);

  logic                   access;
  logic                   wr_ok;     // Offset takes writes
  logic                   rd_ok;     // Offset is mapped
  logic                   wr_en;
  nes_bus_pkg::cpu_data_t dmc_lo;
  nes_bus_pkg::cpu_data_t dmc_hi;
  nes_bus_pkg::cpu_data_t dmc_byte;  // Last fetched sample byte

  assign access   = psel && penable;  // Access phase
  assign pready   = access;           // Never waits
  assign wr_en    = access && pwrite && wr_ok;
  assign pslverr  = access && (pwrite ? !wr_ok : !rd_ok);
  assign spr_start = wr_en && (paddr == dma_regs_pkg::REG_SPR_PAGE);
  assign dmc_addr = {dmc_hi, dmc_lo};

  // Offset decode and read mux
  always_comb begin
    wr_ok  = 1'b0;
    rd_ok  = 1'b1;
    prdata = '0;
    case (paddr)
      dma_regs_pkg::REG_CTRL: begin
        wr_ok     = 1'b1;
        prdata[0] = (video_std == nes_bus_pkg::VIDEO_PAL);
      end
      dma_regs_pkg::REG_SPR_PAGE: begin
        wr_ok  = 1'b1;
        prdata = spr_page;
      end
      dma_regs_pkg::REG_DMC_ADDR_LO: begin
        wr_ok  = 1'b1;
        prdata = dmc_lo;
      end
      dma_regs_pkg::REG_DMC_ADDR_HI: begin
        wr_ok  = 1'b1;
        prdata = dmc_hi;
      end
      dma_regs_pkg::REG_DMC_REQ: begin
        wr_ok     = 1'b1;
        prdata[0] = dmc_req;
      end
      dma_regs_pkg::REG_DMC_DATA: prdata = dmc_byte;  // Read only
      dma_regs_pkg::REG_STATUS: begin
        prdata[dma_regs_pkg::STATUS_SPR_BUSY] = spr_busy;
        prdata[dma_regs_pkg::STATUS_DMC_PEND] = dmc_req;
      end
      default: rd_ok = 1'b0;  // Unmapped, reads as 0
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      video_std <= nes_bus_pkg::VIDEO_NTSC;
      spr_page  <= '0;
      dmc_lo    <= '0;
      dmc_hi    <= '0;
      dmc_req   <= 1'b0;
    end else begin
      if (dmc_ack) dmc_req <= 1'b0;  // Served, a same-clock set below wins
      if (wr_en) begin
        case (paddr)
          dma_regs_pkg::REG_CTRL:        video_std <= nes_bus_pkg::video_std_t'(pwdata[0]);
          dma_regs_pkg::REG_SPR_PAGE:    spr_page  <= pwdata;
          dma_regs_pkg::REG_DMC_ADDR_LO: dmc_lo    <= pwdata;
          dma_regs_pkg::REG_DMC_ADDR_HI: dmc_hi    <= pwdata;
          dma_regs_pkg::REG_DMC_REQ:     if (pwdata[0]) dmc_req <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  // Sample byte from the controller
  always_ff @(posedge clk) begin
    if (dmc_data_valid) dmc_byte <= dmc_data;
  end

endmodule

// File: src/dma_controller.sv
// ----------------------------------------
// Sprite and DMC DMA controller
// Owns the memory bus while copying a page
// to OAM or stealing a cycle for a sample
// ----------------------------------------
`timescale 1ns/10ps
`include "nes_settings.svh"

module dma_controller (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cpu_ce,
  input  logic                   odd_cycle,
  input  logic                   spr_start,
  input  nes_bus_pkg::cpu_data_t spr_page,
  input  logic                   dmc_req,
  input  nes_bus_pkg::cpu_addr_t dmc_addr,
  input  nes_bus_pkg::cpu_data_t mem_rdata,
  output nes_bus_pkg::cpu_addr_t mem_addr,
  output logic                   mem_read,
  output logic                   mem_write,
  output nes_bus_pkg::cpu_data_t mem_wdata,
  output logic                   dmc_ack,
  output nes_bus_pkg::cpu_data_t dmc_data,
  output logic                   dmc_data_valid,
  output logic                   spr_busy,
  output logic                   cpu_halt
);

  localparam logic [7:0] SPR_LAST = 8'(`NES_SPR_BYTES - 1);

  logic [1:0]             spr_state;  // 0 idle, 1 pending, 3 active
  logic                   dmc_state;  // Fetch latched, waiting for even cycle
  logic [7:0]             spr_idx;    // Source byte within the page
  nes_bus_pkg::cpu_data_t spr_latch;  // Byte on its way to OAM
  logic                   spr_act;
  logic                   dmc_fire;   // DMC owns this cycle
  logic                   spr_rd;
  logic                   spr_wr;

  assign spr_act  = spr_state[1];
  assign dmc_fire = dmc_state && !odd_cycle;
  assign spr_rd   = spr_act && !odd_cycle && !dmc_fire;  // Deferred when DMC steals it
  assign spr_wr   = spr_act && odd_cycle;

  // Bus priority: DMC, sprite source, OAM port
  assign mem_addr = dmc_fire   ? dmc_addr :
                    !odd_cycle ? {spr_page, spr_idx} : `NES_OAM_DATA_ADDR;
  assign mem_read  = cpu_ce && (dmc_fire || spr_rd);
  assign mem_write = cpu_ce && spr_wr;
  assign mem_wdata = spr_latch;

  assign dmc_ack        = cpu_ce && dmc_fire;
  assign dmc_data       = mem_rdata;   // Sampled in the read clock
  assign dmc_data_valid = dmc_ack;

  assign spr_busy = |spr_state;
  assign cpu_halt = spr_state[0] || dmc_req;  // Pending or active, or sample wanted

  always_ff @(posedge clk) begin
    if (reset) begin
      spr_state <= 2'd0;
      dmc_state <= 1'b0;
      spr_idx   <= '0;
    end else begin
      if (cpu_ce) begin
        if (!dmc_state && dmc_req && !odd_cycle) dmc_state <= 1'b1;
        if (dmc_fire) dmc_state <= 1'b0;          // Read done this cycle
        if (spr_state == 2'd1 && odd_cycle) spr_state <= 2'd3;  // Arm on odd
        if (spr_act && dmc_fire) spr_state <= 2'd1;  // Idle odd, read again
        if (spr_wr) begin
          spr_idx <= spr_idx + 1'b1;
          if (spr_idx == SPR_LAST) spr_state <= 2'd0;  // Last byte written
        end
      end
      if (spr_start) begin
        spr_state <= 2'd1;  // New page restarts the copy
        spr_idx   <= '0;
      end
    end
  end

  // Hold the source byte for the following odd cycle
  always_ff @(posedge clk) begin
    if (cpu_ce && spr_rd) spr_latch <= mem_rdata;
  end

endmodule

// File: src/nes_dma_top.sv
// ----------------------------------------
// NES DMA subsystem top
// Clock divider, APB registers and the DMA
// controller driving the memory bus
// ----------------------------------------
`timescale 1ns/10ps
`include "nes_settings.svh"

module nes_dma_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`NES_APB_AW-1:0] paddr,
  input  nes_bus_pkg::cpu_data_t pwdata,
  output nes_bus_pkg::cpu_data_t prdata,
  output logic                   pready,
  output logic                   pslverr,
  output nes_bus_pkg::cpu_addr_t mem_addr,
  output logic                   mem_read,
  output logic                   mem_write,
  output nes_bus_pkg::cpu_data_t mem_wdata,
  input  nes_bus_pkg::cpu_data_t mem_rdata,
  output logic                   cpu_halt
);

  nes_bus_pkg::video_std_t video_std;
  logic                    cpu_ce;
  logic                    odd_cycle;
  logic                    spr_start;
  nes_bus_pkg::cpu_data_t  spr_page;
  logic                    spr_busy;
  logic                    dmc_req;
  logic                    dmc_ack;
  nes_bus_pkg::cpu_addr_t  dmc_addr;
  nes_bus_pkg::cpu_data_t  dmc_data;
  logic                    dmc_data_valid;

  nes_clock_div clock_div0 (
    .clk       (clk),
    .reset     (reset),
    .video_std (video_std),
    .cpu_ce    (cpu_ce),
    .odd_cycle (odd_cycle)
  );

  dma_reg_block regs0 (
    .clk            (clk),
    .reset          (reset),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .spr_busy       (spr_busy),
    .dmc_ack        (dmc_ack),
    .dmc_data_valid (dmc_data_valid),
    .dmc_data       (dmc_data),
    .video_std      (video_std),
    .spr_start      (spr_start),
    .spr_page       (spr_page),
    .dmc_req        (dmc_req),
    .dmc_addr       (dmc_addr)
  );

  dma_controller dma0 (
    .clk            (clk),
    .reset          (reset),
    .cpu_ce         (cpu_ce),
    .odd_cycle      (odd_cycle),
    .spr_start      (spr_start),
    .spr_page       (spr_page),
    .dmc_req        (dmc_req),
    .dmc_addr       (dmc_addr),
    .mem_rdata      (mem_rdata),
    .mem_addr       (mem_addr),
    .mem_read       (mem_read),
    .mem_write      (mem_write),
    .mem_wdata      (mem_wdata),
    .dmc_ack        (dmc_ack),
    .dmc_data       (dmc_data),
    .dmc_data_valid (dmc_data_valid),
    .spr_busy       (spr_busy),
    .cpu_halt       (cpu_halt)
  );

endmodule

// File: verif/nes_dma_checker.sv
// ----------------------------------------
// NES DMA bus checker
// Bound assertions on memory strobes, OAM
// writes, APB response and reset state
// ----------------------------------------
`timescale 1ns/10ps
`include "nes_settings.svh"

module nes_dma_checker (
  input logic                   clk,
  input logic                   reset,
  input logic                   psel,
  input logic                   penable,
  input logic                   pready,
  input logic                   mem_read,
  input logic                   mem_write,
  input logic                   cpu_halt,
  input logic                   dmc_ack,
  input nes_bus_pkg::cpu_addr_t mem_addr,
  input nes_bus_pkg::cpu_data_t mem_wdata,
  input nes_bus_pkg::cpu_data_t mem_rdata
);

  int                     fail_cnt = 0;     // Assertion failures so far
  logic                   rst_held = 1'b0;  // Reset seen on an earlier edge
  nes_bus_pkg::cpu_data_t last_rd;          // Byte of the latest bus read

  always @(posedge clk) begin
    rst_held <= reset;
    if (mem_read) last_rd <= mem_rdata;
  end

  // One bus direction per cycle
  rd_wr_excl: assert property (@(posedge clk) disable iff (reset) !(mem_read && mem_write))
    else begin
      $error("mem_read and mem_write high in the same clock");
      fail_cnt++;
    end

  // OAM write carries the byte just read
  oam_write: assert property (@(posedge clk) disable iff (reset)
    mem_write |-> (mem_addr == `NES_OAM_DATA_ADDR) && (mem_wdata == last_rd))
    else begin
      $error("OAM write to %h with %h, last read %h", mem_addr, mem_wdata, last_rd);
      fail_cnt++;
    end

  apb_ready: assert property (@(posedge clk) pready |-> psel && penable)
    else begin
      $error("pready outside the APB access phase");
      fail_cnt++;
    end

  // State is known from the second reset edge on
  reset_quiet: assert property (@(posedge clk)
    reset && rst_held |-> !mem_read && !mem_write && !cpu_halt && !dmc_ack && !pready)
    else begin
      $error("Strobe or halt active during reset");
      fail_cnt++;
    end

endmodule

// File: verif/nes_dma_tb.sv
// ----------------------------------------
// NES DMA testbench
// APB driver, memory model and a table of
// sprite and DMC transfers with checks
// ----------------------------------------
`timescale 1ns/10ps
`include "nes_settings.svh"

module nes_dma_tb;

  typedef struct {
    nes_bus_pkg::video_std_t vstd;
    nes_bus_pkg::cpu_data_t  page;      // Sprite source page
    logic                    dmc_en;
    nes_bus_pkg::cpu_addr_t  dmc_addr;
    int                      dmc_off;   // Clocks from page write to DMC request
  } test_t;

  localparam int NUM_TESTS = 4;
  localparam int TIMEOUT   = NUM_TESTS * (512 * 16 + 200);  // Worst case PAL per entry

  logic                   clk     = 1'b0;
  logic                   reset   = 1'b1;
  logic                   psel    = 1'b0;
  logic                   penable = 1'b0;
  logic                   pwrite  = 1'b0;
  logic [`NES_APB_AW-1:0] paddr   = '0;
  nes_bus_pkg::cpu_data_t pwdata  = '0;
  nes_bus_pkg::cpu_data_t prdata;
  logic                   pready;
  logic                   pslverr;
  nes_bus_pkg::cpu_addr_t mem_addr;
  logic                   mem_read;
  logic                   mem_write;
  nes_bus_pkg::cpu_data_t mem_wdata;
  nes_bus_pkg::cpu_data_t mem_rdata;
  logic                   cpu_halt;

  nes_bus_pkg::cpu_addr_t rd_log[$];       // Read addresses in bus order
  nes_bus_pkg::cpu_addr_t wr_addr_log[$];
  nes_bus_pkg::cpu_data_t wr_data_log[$];
  int                     strobe_time[$];  // Clock of every strobe
  int                     cycles = 0;
  int                     errors = 0;
  int                     passed = 0;
  integer                 seed   = 72;
  test_t                  tests[NUM_TESTS];

  nes_dma_top dut0 (.*);

  bind nes_dma_top nes_dma_checker chk0 (
    .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pready(pready),
    .mem_read(mem_read), .mem_write(mem_write), .cpu_halt(cpu_halt),
    .dmc_ack(dmc_ack), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
  );

  // Memory content is the low address byte XOR the high byte
  function automatic nes_bus_pkg::cpu_data_t mem_byte(input nes_bus_pkg::cpu_addr_t a);
    return a[7:0] ^ a[15:8];
  endfunction

  assign mem_rdata = mem_byte(mem_addr);  // No wait states

  always #2 clk = ~clk;  // 4 ns period

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout, run did not end within %0d clocks", TIMEOUT);
      $display("Finished with errors");
      $finish;
    end
  end

  // Strobes are stable at the falling edge
  always @(negedge clk) begin
    if (!reset && mem_read) begin
      rd_log.push_back(mem_addr);
      strobe_time.push_back(cycles);
    end
    if (!reset && mem_write) begin
      wr_addr_log.push_back(mem_addr);
      wr_data_log.push_back(mem_wdata);
      strobe_time.push_back(cycles);
    end
  end

  task automatic check_data(input string name, input nes_bus_pkg::cpu_data_t got,
                            input nes_bus_pkg::cpu_data_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input nes_bus_pkg::cpu_addr_t got,
                            input nes_bus_pkg::cpu_addr_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // One APB transfer with setup then access phase
  task automatic apb_xfer(input logic wr, input logic [`NES_APB_AW-1:0] addr,
                          input nes_bus_pkg::cpu_data_t wdata,
                          output nes_bus_pkg::cpu_data_t rdata, output logic err);
    @(negedge clk);
    psel   = 1'b1;
    pwrite = wr;
    paddr  = addr;
    pwdata = wdata;
    @(negedge clk);
    penable = 1'b1;
    #1;  // Read data settled mid access phase
    rdata = prdata;
    err   = pslverr;
    if (!pready) begin
      $display("APB slave gave no pready in the access phase at offset %0d", addr);
      errors++;
    end
    @(negedge clk);
    psel    = 1'b0;  // Register updated at the edge before
    penable = 1'b0;
  endtask

  task automatic reg_write(input logic [`NES_APB_AW-1:0] addr,
                           input nes_bus_pkg::cpu_data_t data);
    nes_bus_pkg::cpu_data_t rd;
    logic err;
    apb_xfer(1'b1, addr, data, rd, err);
    check_count("pslverr", err, 0);
  endtask

  task automatic reg_read(input logic [`NES_APB_AW-1:0] addr,
                          output nes_bus_pkg::cpu_data_t data);
    logic err;
    apb_xfer(1'b0, addr, 8'h00, data, err);
    check_count("pslverr", err, 0);
  endtask

  task automatic clear_logs();
    rd_log.delete();
    wr_addr_log.delete();
    wr_data_log.delete();
    strobe_time.delete();
  endtask

  task automatic wait_idle();
    while (cpu_halt) @(negedge clk);  // Halt falls once both engines are idle
  endtask

  task automatic report(input int num, input string name, input int err_before);
    if (errors == err_before) begin
      passed++;
      $display("Test %0d %s: pass", num, name);
    end else begin
      $display("Test %0d %s: %0d errors", num, name, errors - err_before);
    end
  endtask

  // Sprite page copy with an optional DMC fetch stolen from it
  task automatic run_entry(input test_t t);
    nes_bus_pkg::cpu_data_t rd;
    nes_bus_pkg::cpu_addr_t spr_rd[$];
    int dmc_reads;
    reg_write(dma_regs_pkg::REG_CTRL, {7'd0, t.vstd});  // Also restarts the divider
    reg_write(dma_regs_pkg::REG_DMC_ADDR_LO, t.dmc_addr[7:0]);
    reg_write(dma_regs_pkg::REG_DMC_ADDR_HI, t.dmc_addr[15:8]);
    clear_logs();
    reg_write(dma_regs_pkg::REG_SPR_PAGE, t.page);
    check_count("cpu_halt", cpu_halt, 1);
    if (t.dmc_en) begin
      repeat (t.dmc_off) @(negedge clk);
      reg_write(dma_regs_pkg::REG_DMC_REQ, 8'h01);
    end
    wait_idle();
    check_count("write count", wr_data_log.size(), `NES_SPR_BYTES);
    foreach (wr_data_log[n]) begin
      check_addr("mem_addr", wr_addr_log[n], `NES_OAM_DATA_ADDR);
      check_data("mem_wdata", wr_data_log[n], mem_byte({t.page, 8'(n)}));
    end
    dmc_reads = 0;
    foreach (rd_log[i]) begin
      if (rd_log[i] == t.dmc_addr) dmc_reads++;
      else spr_rd.push_back(rd_log[i]);
    end
    check_count("dmc read count", dmc_reads, t.dmc_en ? 1 : 0);
    check_count("sprite read count", spr_rd.size(), `NES_SPR_BYTES);
    foreach (spr_rd[i]) check_addr("mem_addr", spr_rd[i], {t.page, 8'(i)});  // Ascending
    if (t.dmc_en) begin
      reg_read(dma_regs_pkg::REG_DMC_DATA, rd);
      check_data("dmc_data", rd, mem_byte(t.dmc_addr));
    end
    reg_read(dma_regs_pkg::REG_STATUS, rd);
    check_data("status", rd, 8'h00);  // Busy and pending both clear
    // Every CPU cycle strobes while copying alone
    if (!t.dmc_en) begin
      for (int i = 1; i < strobe_time.size(); i++) begin
        if (t.vstd == nes_bus_pkg::VIDEO_NTSC)
          check_count("strobe spacing", strobe_time[i] - strobe_time[i-1], 12);
        else if (i >= 5)
          check_count("five strobe spacings", strobe_time[i] - strobe_time[i-5], 64);
      end
    end
  endtask

  initial begin
    nes_bus_pkg::cpu_data_t rd;
    logic err;
    int err0;
    tests[0] = '{nes_bus_pkg::VIDEO_NTSC, 8'h03, 1'b0, 16'h0000, 0};
    tests[1] = '{nes_bus_pkg::VIDEO_PAL,  8'h80, 1'b0, 16'h0000, 0};
    tests[2] = '{nes_bus_pkg::VIDEO_NTSC, 8'h12, 1'b1, 16'h4567, 0};
    tests[3] = '{nes_bus_pkg::VIDEO_PAL,  8'hc5, 1'b1, 16'hc0de, 0};
    foreach (tests[i]) tests[i].dmc_off = 40 + ($unsigned($random(seed)) % 4000);
    repeat (5) @(negedge clk);
    reset = 1'b0;

    err0 = errors;
    check_count("cpu_halt", cpu_halt, 0);
    reg_read(dma_regs_pkg::REG_STATUS, rd);
    check_data("status", rd, 8'h00);
    reg_write(dma_regs_pkg::REG_CTRL, 8'h01);
    reg_read(dma_regs_pkg::REG_CTRL, rd);
    check_data("ctrl", rd, 8'h01);
    reg_write(dma_regs_pkg::REG_CTRL, 8'h00);
    reg_write(dma_regs_pkg::REG_DMC_ADDR_LO, 8'h34);
    reg_write(dma_regs_pkg::REG_DMC_ADDR_HI, 8'h1a);
    reg_read(dma_regs_pkg::REG_DMC_ADDR_LO, rd);
    check_data("dmc_addr_lo", rd, 8'h34);
    reg_read(dma_regs_pkg::REG_DMC_ADDR_HI, rd);
    check_data("dmc_addr_hi", rd, 8'h1a);
    apb_xfer(1'b1, 5'd7, 8'hff, rd, err);  // Unmapped write
    check_count("pslverr", err, 1);
    apb_xfer(1'b0, 5'd7, 8'h00, rd, err);
    check_count("pslverr", err, 1);
    check_data("prdata", rd, 8'h00);
    apb_xfer(1'b1, dma_regs_pkg::REG_STATUS, 8'h03, rd, err);  // Read only
    check_count("pslverr", err, 1);
    reg_read(dma_regs_pkg::REG_STATUS, rd);
    check_data("status", rd, 8'h00);
    reg_read(dma_regs_pkg::REG_CTRL, rd);
    check_data("ctrl", rd, 8'h00);
    report(1, "register access", err0);

    err0 = errors;
    clear_logs();
    reg_write(dma_regs_pkg::REG_DMC_REQ, 8'h01);
    wait_idle();
    check_count("dmc read count", rd_log.size(), 1);
    if (rd_log.size() == 1) check_addr("mem_addr", rd_log[0], 16'h1a34);
    check_count("write count", wr_data_log.size(), 0);
    reg_read(dma_regs_pkg::REG_DMC_DATA, rd);
    check_data("dmc_data", rd, mem_byte(16'h1a34));
    reg_read(dma_regs_pkg::REG_STATUS, rd);
    check_data("status", rd, 8'h00);
    report(2, "DMC fetch alone", err0);

    foreach (tests[i]) begin
      err0 = errors;
      run_entry(tests[i]);
      report(i + 3, $sformatf("sprite page %h %s DMC %0d", tests[i].page,
             tests[i].vstd.name(), tests[i].dmc_en), err0);
    end

    errors += dut0.chk0.fail_cnt;  // Assertion failures from the bound checker
    $display("%0d tests passed, %0d errors", passed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+src
src/nes_bus_pkg.sv
src/dma_regs_pkg.sv
src/nes_clock_div.sv
src/dma_reg_block.sv
src/dma_controller.sv
src/nes_dma_top.sv
verif/nes_dma_checker.sv
verif/nes_dma_tb.sv
